// ==== Makefile ====
TOP := commandTimersTb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f commandTimers.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== commandTimers.f ====
+incdir+rtl
rtl/commandTimersPkg.sv
rtl/ioCommandInterface.sv
rtl/timerCell.sv
rtl/commandTimers.sv
testbench/clockGen.sv
testbench/commandTimersTb.sv

// ==== rtl/commandTimers.sv ====
`default_nettype none

`include "commandTimers_config.svh"

module commandTimers
    import commandTimersPkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         arstN,
    input  wire logic                         ioInAck,
    output logic                              ioInReq,
    input  wire logic [3:0]                   minorOpcodeIn,
    input  wire logic [3:0]                   registerDestIn,
    input  wire logic [`TIMER_DATA_WIDTH-1:0] dataAddrIn,
    input  wire logic [`TIMER_DATA_WIDTH-1:0] dataIn,
    output logic      [`TIMER_COUNT-1:0]      timerOutAck,
    input  wire logic [`TIMER_COUNT-1:0]      timerOutReq,
    output timerResult_t                      resultOut [`TIMER_COUNT]
);

    localparam int selBits = $clog2(`TIMER_COUNT);
    localparam int padBits = 32 - `TIMER_WAIT_BITS;

    logic [31:0]             counter;
    logic [31:0]             scaledWait;
    logic [31:0]             deadline;
    logic                    cmdValid;
    logic                    cmdReady;
    timerCmd_t               cmd;
    timerOp_e                op;
    logic [`TIMER_COUNT-1:0] cellReq;
    logic [`TIMER_COUNT-1:0] cmdAccept;

    ioCommandInterface #(
        .dataWidth(`TIMER_DATA_WIDTH)
    ) i_ioCommandInterface (
        .clk           (clk),
        .arstN         (arstN),
        .ioInAck       (ioInAck),
        .ioInReq       (ioInReq),
        .minorOpcodeIn (minorOpcodeIn),
        .registerDestIn(registerDestIn),
        .dataAddrIn    (dataAddrIn),
        .dataIn        (dataIn),
        .cmdValid      (cmdValid),
        .cmdReady      (cmdReady),
        .cmd           (cmd)
    );

    // Free-running cycle counter shared by all cells
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            counter <= '0;
        end else begin
            counter <= counter + 32'd1;
        end
    end

    // 32x keeps the top bits of a 27-bit wait inside 32 bits
    always_comb begin
        scaledWait = {{padBits{1'b0}}, cmd.waitTime};
        if (cmd.prescale) begin
            scaledWait = scaledWait << `TIMER_PRESCALE_SHIFT;
        end
    end

    assign deadline = counter + scaledWait;

    assign op = timerOp_e'({cmd.isStore, cmd.cmdBit});

    assign cmdReady = cellReq[cmd.select];

    for (genvar i = 0; i < `TIMER_COUNT; i++) begin : genTimer
        // Only the addressed cell sees the accept pulse
        assign cmdAccept[i] = cmdValid && cmdReady && (cmd.select == selBits'(i));

        timerCell i_timerCell (
            .clk        (clk),
            .arstN      (arstN),
            .counter    (counter),
            .deadlineIn (deadline),
            .cmdAccept  (cmdAccept[i]),
            .op         (op),
            .regDestIn  (cmd.regDest),
            .timerInReq (cellReq[i]),
            .timerOutAck(timerOutAck[i]),
            .timerOutReq(timerOutReq[i]),
            .resultOut  (resultOut[i])
        );
    end

endmodule

`default_nettype wire

// ==== rtl/commandTimersPkg.sv ====
`default_nettype none

`include "commandTimers_config.svh"

package commandTimersPkg;

    // Encoded as {isStore, cmdBit}
    typedef enum logic [1:0] {
        opCheck = 2'b00,
        opWait  = 2'b01,
        opClear = 2'b10,
        opSet   = 2'b11
    } timerOp_e;

    // Command word fields plus the opcode and destination captured with the high beat
    typedef struct packed {
        logic                            isStore;
        logic                            cmdBit;
        logic [$clog2(`TIMER_COUNT)-1:0] select;
        logic                            prescale;
        logic [`TIMER_WAIT_BITS-1:0]     waitTime;
        logic [3:0]                      regDest;
    } timerCmd_t;

    typedef struct packed {
        logic [3:0]  regDest;
        logic [31:0] data;
    } timerResult_t;

endpackage

`default_nettype wire

// ==== rtl/commandTimers_config.svh ====
`ifndef COMMAND_TIMERS_CONFIG_SVH
`define COMMAND_TIMERS_CONFIG_SVH

// Width of one beat on the I/O command port
`define TIMER_DATA_WIDTH 16

// Number of timer cells behind the shared counter
`define TIMER_COUNT 8

// Prescale bit set gives 32x
`define TIMER_PRESCALE_SHIFT 5

// Wait field of the command word
`define TIMER_WAIT_BITS 27

`endif

// ==== rtl/ioCommandInterface.sv ====
`default_nettype none

`include "commandTimers_config.svh"

module ioCommandInterface
    import commandTimersPkg::*;
#(
    parameter int dataWidth = `TIMER_DATA_WIDTH
) (
    input  wire logic                 clk,
    input  wire logic                 arstN,
    input  wire logic                 ioInAck,
    output logic                      ioInReq,
    input  wire logic [3:0]           minorOpcodeIn,
    input  wire logic [3:0]           registerDestIn,
    input  wire logic [dataWidth-1:0] dataAddrIn,
    input  wire logic [dataWidth-1:0] dataIn,
    output logic                      cmdValid,
    input  wire logic                 cmdReady,
    output timerCmd_t                 cmd
);

    localparam int wordWidth = 32;
    localparam int bufCount = (dataWidth >= wordWidth) ? 1 : wordWidth / dataWidth;
    localparam int idxBits = (bufCount > 1) ? $clog2(bufCount) : 1;
    localparam int selBits = $clog2(`TIMER_COUNT);
    localparam int prescalePos = `TIMER_WAIT_BITS;
    localparam int selectLsb = `TIMER_WAIT_BITS + 1;
    localparam int cmdBitPos = wordWidth - 1;

    logic [dataWidth-1:0] beatBuf [bufCount];
    logic [idxBits-1:0]   beatIdx;
    logic [wordWidth-1:0] cmdWord;
    logic                 beatFire;
    logic                 lastBeat;
    logic                 cmdTaken;

    // No new beats while a command waits for its timer
    assign ioInReq = !cmdValid;

    assign beatFire = ioInAck && ioInReq;
    assign cmdTaken = cmdValid && cmdReady;

    // Low address bits pick the slot; a full-width port has just one
    assign beatIdx = (bufCount > 1) ? dataAddrIn[idxBits-1:0] : '0;
    assign lastBeat = (beatIdx == idxBits'(bufCount - 1));

    // Top slot comes straight from the completing beat
    always_comb begin
        cmdWord = '0;
        for (int i = 0; i < bufCount; i++) begin
            if (i == bufCount - 1) begin
                cmdWord[i*dataWidth +: dataWidth] = dataIn;
            end else begin
                cmdWord[i*dataWidth +: dataWidth] = beatBuf[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beatFire) begin
            beatBuf[beatIdx] <= dataIn;
        end
    end

    // Store bit and destination travel with the last beat
    always_ff @(posedge clk) begin
        if (beatFire && lastBeat) begin
            cmd.isStore  <= minorOpcodeIn[2];
            cmd.cmdBit   <= cmdWord[cmdBitPos];
            cmd.select   <= cmdWord[selectLsb +: selBits];
            cmd.prescale <= cmdWord[prescalePos];
            cmd.waitTime <= cmdWord[`TIMER_WAIT_BITS-1:0];
            cmd.regDest  <= registerDestIn;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cmdValid <= 1'b0;
        end else if (beatFire && lastBeat) begin
            cmdValid <= 1'b1;
        end else if (cmdTaken) begin
            cmdValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/timerCell.sv ====
`default_nettype none

module timerCell
    import commandTimersPkg::*;
(
    input  wire logic        clk,
    input  wire logic        arstN,
    input  wire logic [31:0] counter,
    input  wire logic [31:0] deadlineIn,
    input  wire logic        cmdAccept,
    input  var  timerOp_e    op,
    input  wire logic [3:0]  regDestIn,
    output logic             timerInReq,
    output logic             timerOutAck,
    input  wire logic        timerOutReq,
    output timerResult_t     resultOut
);

    logic [31:0] deadline;
    logic [31:0] remaining;
    logic        armed;
    logic        busy;
    logic        waitPending;
    logic [3:0]  waitDest;
    logic        isStoreOp;
    logic        setAccept;
    logic        clearAccept;
    logic        checkAccept;
    logic        waitAccept;
    logic        waitDone;
    logic        resultTaken;

    // Upper half of the range counts as already passed
    assign remaining = deadline - counter;
    assign busy = armed && (remaining != '0) && !remaining[31];

    // Stores never stall; loads need an empty slot and no Wait in flight
    assign isStoreOp = (op == opSet) || (op == opClear);
    assign timerInReq = isStoreOp || (!timerOutAck && !waitPending);

    assign setAccept = cmdAccept && (op == opSet);
    assign clearAccept = cmdAccept && (op == opClear);
    assign checkAccept = cmdAccept && (op == opCheck);
    assign waitAccept = cmdAccept && (op == opWait);

    // A Clear drops busy, so a pending Wait finishes on its own
    assign waitDone = waitPending && !busy;
    assign resultTaken = timerOutAck && timerOutReq;

    always_ff @(posedge clk) begin
        if (setAccept) begin
            deadline <= deadlineIn;
        end
    end

    // Expired timers disarm so the compare never wraps back to busy
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            armed <= 1'b0;
        end else if (setAccept) begin
            armed <= 1'b1;
        end else if (clearAccept || !busy) begin
            armed <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            waitPending <= 1'b0;
        end else if (waitAccept) begin
            waitPending <= 1'b1;
        end else if (waitDone) begin
            waitPending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (waitAccept) begin
            waitDest <= regDestIn;
        end
    end

    // One-entry result slot
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            timerOutAck <= 1'b0;
        end else if (checkAccept || waitDone) begin
            timerOutAck <= 1'b1;
        end else if (resultTaken) begin
            timerOutAck <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (checkAccept) begin
            resultOut <= '{regDest: regDestIn, data: 32'(busy)};
        end else if (waitDone) begin
            resultOut <= '{regDest: waitDest, data: 32'd0};
        end
    end

endmodule

`default_nettype wire

// ==== testbench/clockGen.sv ====
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Reset held for five rising edges
    initial begin
        arstN = 1'b0;
        repeat (5) @(posedge clk);
        #2 arstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/commandTimersTb.sv ====
`default_nettype none

`include "commandTimers_config.svh"

module commandTimersTb
    import commandTimersPkg::*;
;

    localparam int waitIters = 6;
    localparam int numTests = 6;
    // Worst-case waits of tests 2, 3 and 6 plus overhead per test
    localparam int cycleLimit = 200 + waitIters * 256 + 260 + 200 * numTests;

    logic clk;
    logic arstN;
    logic ioInAck;
    logic ioInReq;
    logic [3:0] minorOpcodeIn;
    logic [3:0] registerDestIn;
    logic [`TIMER_DATA_WIDTH-1:0] dataAddrIn;
    logic [`TIMER_DATA_WIDTH-1:0] dataIn;
    logic [`TIMER_COUNT-1:0] timerOutAck;
    logic [`TIMER_COUNT-1:0] timerOutReq;
    timerResult_t resultOut [`TIMER_COUNT];

    logic [31:0] seed = 32'hc9db;
    int cycleCnt = 0;
    int errCount = 0;
    int checkCount = 0;
    int testsPassed = 0;
    int errAtStart;
    int beatEdge;
    // Reference model with one entry per timer
    logic modelArmed [`TIMER_COUNT];
    int modelSetEdge [`TIMER_COUNT];
    int modelScaled [`TIMER_COUNT];

    clockGen i_clockGen (.clk(clk), .arstN(arstN));

    commandTimers i_commandTimers (
        .clk           (clk),
        .arstN         (arstN),
        .ioInAck       (ioInAck),
        .ioInReq       (ioInReq),
        .minorOpcodeIn (minorOpcodeIn),
        .registerDestIn(registerDestIn),
        .dataAddrIn    (dataAddrIn),
        .dataIn        (dataIn),
        .timerOutAck   (timerOutAck),
        .timerOutReq   (timerOutReq),
        .resultOut     (resultOut)
    );

    always @(posedge clk) begin
        cycleCnt = cycleCnt + 1;
        if (cycleCnt > cycleLimit) begin
            $display("Timeout: no progress after %0d cycles", cycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic int randRange(int lo, int hi);
        return lo + int'((nextRand() >> 8) % (hi - lo + 1));
    endfunction

    // Check busy as seen in the cycle after the high beat edge
    function automatic logic modelBusy(int t, int hiEdge);
        return modelArmed[t] && (hiEdge < modelSetEdge[t] + modelScaled[t] - 1);
    endfunction

    task automatic checkValue(string name, logic [35:0] actual, logic [35:0] expected);
        checkCount++;
        if (actual !== expected) begin
            $display("FAILED at %0t: %s actual %0h expected %0h", $time, name, actual, expected);
            errCount++;
        end
    endtask

    task automatic sendBeat(logic hi, logic store, logic [3:0] dest, logic [15:0] data);
        while (!ioInReq) begin
            @(posedge clk);
            #2;
        end
        ioInAck = 1'b1;
        dataAddrIn = {15'd0, hi};
        dataIn = data;
        minorOpcodeIn = {1'b0, store, 2'b00};
        registerDestIn = dest;
        @(posedge clk);
        #2;
        beatEdge = cycleCnt;
        ioInAck = 1'b0;
    endtask

    task automatic sendCommand(int t, logic store, logic cmdBit, logic presc, int waitTime,
                               logic [3:0] dest);
        logic [31:0] word;
        word = {cmdBit, 3'(t), presc, 27'(waitTime)};
        sendBeat(1'b0, store, dest, word[15:0]);
        sendBeat(1'b1, store, dest, word[31:16]);
    endtask

    task automatic armTimer(int t, logic presc, int waitTime);
        sendCommand(t, 1'b1, 1'b1, presc, waitTime, 4'd0);
        modelArmed[t] = 1'b1;
        modelSetEdge[t] = beatEdge + 1;
        modelScaled[t] = presc ? (waitTime << `TIMER_PRESCALE_SHIFT) : waitTime;
    endtask

    task automatic disarmTimer(int t);
        sendCommand(t, 1'b1, 1'b0, 1'b0, 0, 4'd0);
        modelArmed[t] = 1'b0;
    endtask

    // Waits for the ack, checks the result, then consumes it
    task automatic getResult(int t, logic [3:0] dest, logic [31:0] data, output int ackEdge);
        do begin
            @(posedge clk);
            #2;
        end while (!timerOutAck[t]);
        ackEdge = cycleCnt;
        checkValue($sformatf("resultOut[%0d]", t), resultOut[t], {dest, data});
        checkValue("timerOutAck others", 36'(timerOutAck & ~(8'd1 << t)), 36'd0);
        timerOutReq[t] = 1'b1;
        @(posedge clk);
        #2;
        timerOutReq[t] = 1'b0;
    endtask

    task automatic queryBusy(int t, logic [3:0] dest);
        int ackEdge;
        sendCommand(t, 1'b0, 1'b0, 1'b0, 0, dest);
        getResult(t, dest, 32'(modelBusy(t, beatEdge)), ackEdge);
    endtask

    // Wait ack must land in [expiry, expiry + 4]
    task automatic awaitExpiry(int t, logic [3:0] dest, int lo, int hi);
        int ackEdge;
        sendCommand(t, 1'b0, 1'b1, 1'b0, 0, dest);
        getResult(t, dest, 32'd0, ackEdge);
        if (ackEdge < lo || ackEdge > hi) begin
            $display("Wait ack on timer %0d came at edge %0d, outside %0d to %0d",
                     t, ackEdge, lo, hi);
            errCount++;
        end
    endtask

    task automatic endTest(string name);
        if (errCount == errAtStart) begin
            testsPassed++;
            $display("%s: pass", name);
        end else begin
            $display("%s: FAIL with %0d errors", name, errCount - errAtStart);
        end
        errAtStart = errCount;
    endtask

    initial begin
        int t;
        int u;
        int w;
        int w2;
        int d;
        int lo;
        int stall;
        timerResult_t held;
        ioInAck = 1'b0;
        minorOpcodeIn = '0;
        registerDestIn = '0;
        dataAddrIn = '0;
        dataIn = '0;
        timerOutReq = '0;
        for (int i = 0; i < `TIMER_COUNT; i++) begin
            modelArmed[i] = 1'b0;
            modelSetEdge[i] = 0;
            modelScaled[i] = 0;
        end
        errAtStart = 0;
        wait (arstN);
        @(posedge clk);
        #2;

        for (int i = 0; i < `TIMER_COUNT; i++) begin
            queryBusy(i, 4'(randRange(0, 15)));
        end
        endTest("Test 1 check after reset");

        t = randRange(0, 7);
        w = randRange(8, 200);
        armTimer(t, 1'b0, w);
        queryBusy(t, 4'(randRange(0, 15)));
        while (cycleCnt < modelSetEdge[t] + w + 4) begin
            @(posedge clk);
            #2;
        end
        queryBusy(t, 4'(randRange(0, 15)));
        endTest("Test 2 set then check");

        for (int i = 0; i < waitIters; i++) begin
            t = randRange(0, 7);
            if (i % 2 == 0) begin
                armTimer(t, 1'b0, randRange(4, 200));
            end else begin
                armTimer(t, 1'b1, randRange(1, 8));
            end
            lo = modelSetEdge[t] + modelScaled[t];
            awaitExpiry(t, 4'(randRange(0, 15)), lo, lo + 4);
        end
        endTest("Test 3 wait timing");

        t = randRange(0, 7);
        d = randRange(0, 15);
        armTimer(t, 1'b0, 1000);
        sendCommand(t, 1'b0, 1'b1, 1'b0, 0, 4'(d));
        disarmTimer(t);
        lo = beatEdge + 1;
        begin
            int ackEdge;
            getResult(t, 4'(d), 32'd0, ackEdge);
            if (ackEdge > lo + 4) begin
                $display("Clear did not release the pending Wait on timer %0d in time", t);
                errCount++;
            end
        end
        queryBusy(t, 4'(randRange(0, 15)));
        endTest("Test 4 clear releases wait");

        t = randRange(0, 7);
        u = (t + randRange(1, 7)) % `TIMER_COUNT;
        d = randRange(0, 15);
        sendCommand(t, 1'b0, 1'b0, 1'b0, 0, 4'(d));
        do begin
            @(posedge clk);
            #2;
        end while (!timerOutAck[t]);
        held = resultOut[t];
        checkValue("resultOut held", held, {4'(d), 32'd0});
        w2 = randRange(0, 15);
        sendCommand(t, 1'b0, 1'b0, 1'b0, 0, 4'(w2));
        // Low beat of a Check to the other timer waits with ack high
        ioInAck = 1'b1;
        dataAddrIn = '0;
        dataIn = '0;
        stall = randRange(5, 20);
        for (int i = 0; i < stall; i++) begin
            @(posedge clk);
            #2;
            checkValue("timerOutAck stalled", 36'(timerOutAck[t]), 36'd1);
            checkValue("resultOut stalled", resultOut[t], held);
            checkValue("ioInReq", 36'(ioInReq), 36'd0);
        end
        timerOutReq[t] = 1'b1;
        @(posedge clk);
        #2;
        timerOutReq[t] = 1'b0;
        begin
            int ackEdge;
            getResult(t, 4'(w2), 32'd0, ackEdge);
        end
        // Held low beat went through once ioInReq came back
        d = randRange(0, 15);
        sendBeat(1'b1, 1'b0, 4'(d), {1'b0, 3'(u), 12'd0});
        begin
            int ackEdge;
            getResult(u, 4'(d), 32'(modelBusy(u, beatEdge)), ackEdge);
        end
        endTest("Test 5 back-pressure");

        t = randRange(0, 7);
        d = randRange(0, 15);
        // High beat alone runs a Check with the stale low half
        sendBeat(1'b1, 1'b0, 4'(d), {1'b0, 3'(t), 12'd0});
        begin
            int ackEdge;
            getResult(t, 4'(d), 32'd0, ackEdge);
        end
        w = randRange(4, 40);
        w2 = w + randRange(60, 200);
        sendBeat(1'b0, 1'b1, 4'd0, 16'(w));
        sendBeat(1'b0, 1'b1, 4'd0, 16'(w2));
        sendBeat(1'b1, 1'b1, 4'd0, {1'b1, 3'(t), 12'd0});
        modelArmed[t] = 1'b1;
        modelSetEdge[t] = beatEdge + 1;
        modelScaled[t] = w2;
        queryBusy(t, 4'(randRange(0, 15)));
        lo = modelSetEdge[t] + w2;
        awaitExpiry(t, 4'(randRange(0, 15)), lo, lo + 4);
        endTest("Test 6 beat order");

        $display("Tests passed %0d of %0d, checks %0d, errors %0d",
                 testsPassed, numTests, checkCount, errCount);
        if (errCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
